// ==== sim/design_info_cases.txt ====
// port (0, 1, 2 = tie pair) write addr wdata exp_rdata exp_pslverr
// Two port 2 lines in a row start together, first on port 0, second on port 1
0 0 00000000 00000000 6f666e69 0
0 0 00000004 00000000 616c705f 0
0 0 00000008 00000000 726f6674 0
0 0 0000000c 00000000 2020206d 0
0 0 00000010 00000000 745f7768 0
0 0 00000014 00000000 206d6165 0
0 0 00000018 00000000 20202020 0
0 0 0000001c 00000000 20202020 0
0 0 00000020 00000000 65746164 0
0 0 00000024 00000000 746f6e5f 0
0 0 00000028 00000000 6365725f 0
0 0 0000002c 00000000 6564726f 0
0 0 00000030 00000000 20202064 0
0 0 00000034 00000000 656d6f68 0
0 0 00000038 00000000 7065725f 0
0 0 0000003c 00000000 7469736f 0
0 0 00000040 00000000 2079726f 0
0 0 00000044 00000000 342e3176 0
0 0 00000048 00000000 2020322e 0
0 0 0000004c 00000000 302e3276 0
0 0 00000050 00000000 2020372e 0
0 0 00000054 00000000 00000000 1
0 0 000000fc 00000000 00000000 1
0 0 00000001 00000000 00000000 1
1 0 00000028 00000000 6365725f 0
1 0 00000044 00000000 342e3176 0
1 0 00000050 00000000 2020372e 0
2 0 00000000 00000000 6f666e69 0
2 0 0000004c 00000000 302e3276 0
0 1 00000008 deadbeef 00000000 0
0 0 00000008 00000000 726f6674 0
2 0 00000034 00000000 656d6f68 0
2 0 00000030 00000000 20202064 0

// ==== src.f ====
source/design_info_pkg.sv
source/apb_if.sv
source/apb_port_arbiter.sv
source/string_word_select.sv
source/design_info_regs.sv
source/design_info_top.sv
sim/tb_design_info.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_design_info
RTL_TOP ?= design_info_top
FILELIST ?= src.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall
PASS_TEXT ?= sim passed

RTL_FILES := $(filter-out sim/%,$(shell cat $(FILELIST)))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) $(RTL_FILES) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/tb_design_info.sv ====
module tb_design_info import design_info_pkg::*;;

	localparam int CASE_WORDS = 6;
	localparam int MAX_CASES = 64;
	localparam logic [31:0] END_MARK = 32'hffff_ffff;

	logic clk;
	logic rst_n;
	logic s0_psel;
	logic s0_penable;
	logic s0_pwrite;
	logic [BW_ADDR-1:0] s0_paddr;
	logic [BW_DATA-1:0] s0_pwdata;
	logic [BW_DATA-1:0] s0_prdata;
	logic s0_pready;
	logic s0_pslverr;
	logic s1_psel;
	logic s1_penable;
	logic s1_pwrite;
	logic [BW_ADDR-1:0] s1_paddr;
	logic [BW_DATA-1:0] s1_pwdata;
	logic [BW_DATA-1:0] s1_prdata;
	logic s1_pready;
	logic s1_pslverr;

	// One case is port, write, address, write data, read data, error
	logic [31:0] case_mem [MAX_CASES*CASE_WORDS];
	int case_count;
	int cycles = 0;
	int cycle_limit = 0;
	int mismatch_errors = 0;
	int other_errors = 0;
	logic s0_active = 1'b0;
	logic s1_active = 1'b0;
	logic last_served = 1'b1;

	design_info_top dut (.*);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// **************************************************
	// Timeout and pready monitor
	// **************************************************
	always @(posedge clk)
	begin
		cycles++;
		if (cycle_limit > 0 && cycles > cycle_limit)
		begin
			$display("Timeout after %0d cycles, a transfer never completed", cycles);
			$display("Errors: %0d mismatches, %0d other failures", mismatch_errors,
				other_errors);
			$display("sim failed");
			$finish;
		end
	end

	// Covers the idle time after reset too
	always @(negedge clk)
	begin
		if (rst_n)
		begin
			assert (s0_active || !s0_pready)
			else
			begin
				other_errors++;
				$display("Port 0 saw pready with no transfer open, cycle %0d", cycles);
			end
			assert (s1_active || !s1_pready)
			else
			begin
				other_errors++;
				$display("Port 1 saw pready with no transfer open, cycle %0d", cycles);
			end
		end
	end

	// **************************************************
	// Port drivers and response check
	// **************************************************
	task automatic transfer_port0(input logic wr, input logic [31:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err,
		output int done_cycle);
		@(posedge clk);
		s0_active = 1'b1;
		s0_psel <= 1'b1;
		s0_penable <= 1'b0;
		s0_pwrite <= wr;
		s0_paddr <= addr;
		s0_pwdata <= wdata;
		@(posedge clk);
		s0_penable <= 1'b1;
		@(negedge clk);
		while (!s0_pready)
		begin
			@(negedge clk);
		end
		rdata = s0_prdata;
		err = s0_pslverr;
		done_cycle = cycles;
		@(posedge clk);
		s0_psel <= 1'b0;
		s0_penable <= 1'b0;
		s0_active = 1'b0;
	endtask

	task automatic transfer_port1(input logic wr, input logic [31:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err,
		output int done_cycle);
		@(posedge clk);
		s1_active = 1'b1;
		s1_psel <= 1'b1;
		s1_penable <= 1'b0;
		s1_pwrite <= wr;
		s1_paddr <= addr;
		s1_pwdata <= wdata;
		@(posedge clk);
		s1_penable <= 1'b1;
		@(negedge clk);
		while (!s1_pready)
		begin
			@(negedge clk);
		end
		rdata = s1_prdata;
		err = s1_pslverr;
		done_cycle = cycles;
		@(posedge clk);
		s1_psel <= 1'b0;
		s1_penable <= 1'b0;
		s1_active = 1'b0;
	endtask

	task automatic check_response(input int port, input logic [31:0] exp_data,
		input logic [31:0] got_data, input logic exp_err, input logic got_err);
		assert (got_data === exp_data)
		else
		begin
			mismatch_errors++;
			$display("Mismatch port %0d prdata: expected %h, got %h", port, exp_data,
				got_data);
		end
		assert (got_err === exp_err)
		else
		begin
			mismatch_errors++;
			$display("Mismatch port %0d pslverr: expected %h, got %h", port, exp_err,
				got_err);
		end
	endtask

	// **************************************************
	// Main sequence
	// **************************************************
	initial
	begin
		int n;
		int base;
		int c0;
		int c1;
		logic [31:0] rd0;
		logic [31:0] rd1;
		logic err0;
		logic err1;
		logic first;

		rst_n <= 1'b0;
		s0_psel <= 1'b0;
		s0_penable <= 1'b0;
		s0_pwrite <= 1'b0;
		s0_paddr <= '0;
		s0_pwdata <= '0;
		s1_psel <= 1'b0;
		s1_penable <= 1'b0;
		s1_pwrite <= 1'b0;
		s1_paddr <= '0;
		s1_pwdata <= '0;

		for (int i = 0; i < MAX_CASES * CASE_WORDS; i++)
		begin
			case_mem[i] = END_MARK;
		end
		$readmemh("sim/design_info_cases.txt", case_mem);
		case_count = 0;
		while (case_count < MAX_CASES && case_mem[case_count*CASE_WORDS] != END_MARK)
		begin
			case_count++;
		end
		if (case_count == 0)
		begin
			other_errors++;
			$display("No cases were read from the cases file");
		end
		cycle_limit = case_count * 20 + 100;

		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		// Idle cycles, the monitor flags any pready here
		repeat (4) @(negedge clk);

		n = 0;
		while (n < case_count)
		begin
			base = n * CASE_WORDS;
			if (case_mem[base] == 2)
			begin
				// Tie pair, first line on port 0 and second on port 1
				fork
					transfer_port0(case_mem[base+1][0], case_mem[base+2], case_mem[base+3],
						rd0, err0, c0);
					transfer_port1(case_mem[base+7][0], case_mem[base+8], case_mem[base+9],
						rd1, err1, c1);
				join
				check_response(0, case_mem[base+4], rd0, case_mem[base+5][0], err0);
				check_response(1, case_mem[base+10], rd1, case_mem[base+11][0], err1);
				assert (rd0 !== case_mem[base+10] && rd1 !== case_mem[base+4])
				else
				begin
					other_errors++;
					$display("A port returned the read data meant for the other port");
				end
				// Port not served last goes first
				first = ~last_served;
				assert (first ? (c1 < c0) : (c0 < c1))
				else
				begin
					other_errors++;
					$display("Port %0d was not served first on a tie", first);
				end
				last_served = ~first;
				n += 2;
			end
			else
			begin
				if (case_mem[base] == 0)
					transfer_port0(case_mem[base+1][0], case_mem[base+2], case_mem[base+3],
						rd0, err0, c0);
				else
					transfer_port1(case_mem[base+1][0], case_mem[base+2], case_mem[base+3],
						rd0, err0, c0);
				check_response(int'(case_mem[base]), case_mem[base+4], rd0,
					case_mem[base+5][0], err0);
				last_served = case_mem[base][0];
				n++;
			end
		end

		$display("Errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
		if (mismatch_errors == 0 && other_errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// ==== source/design_info_top.sv ====
module design_info_top import design_info_pkg::*;
(
	input logic clk,
	input logic rst_n,

	input logic s0_psel,
	input logic s0_penable,
	input logic s0_pwrite,
	input logic [BW_ADDR-1:0] s0_paddr,
	input logic [BW_DATA-1:0] s0_pwdata,
	output logic [BW_DATA-1:0] s0_prdata,
	output logic s0_pready,
	output logic s0_pslverr,

	input logic s1_psel,
	input logic s1_penable,
	input logic s1_pwrite,
	input logic [BW_ADDR-1:0] s1_paddr,
	input logic [BW_DATA-1:0] s1_pwdata,
	output logic [BW_DATA-1:0] s1_prdata,
	output logic s1_pready,
	output logic s1_pslverr
);

	apb_if p0_bus ();
	apb_if p1_bus ();
	apb_if regs_bus ();

	// Port 0, typically the processor data side
	assign p0_bus.psel = s0_psel;
	assign p0_bus.penable = s0_penable;
	assign p0_bus.pwrite = s0_pwrite;
	assign p0_bus.paddr = s0_paddr;
	assign p0_bus.pwdata = s0_pwdata;
	assign s0_prdata = p0_bus.prdata;
	assign s0_pready = p0_bus.pready;
	assign s0_pslverr = p0_bus.pslverr;

	// Port 1, typically debug
	assign p1_bus.psel = s1_psel;
	assign p1_bus.penable = s1_penable;
	assign p1_bus.pwrite = s1_pwrite;
	assign p1_bus.paddr = s1_paddr;
	assign p1_bus.pwdata = s1_pwdata;
	assign s1_prdata = p1_bus.prdata;
	assign s1_pready = p1_bus.pready;
	assign s1_pslverr = p1_bus.pslverr;

	apb_port_arbiter u_arbiter
	(
		.clk(clk),
		.rst_n(rst_n),
		.port0(p0_bus.completer),
		.port1(p1_bus.completer),
		.target(regs_bus.requester)
	);

	design_info_regs u_regs
	(
		.bus(regs_bus.completer)
	);

endmodule

// ==== source/design_info_regs.sv ====
module design_info_regs import design_info_pkg::*;
(
	apb_if.completer bus
);

	localparam int BW_BYTE_SEL = $clog2(BW_DATA / BITS_PER_CHAR);
	localparam int BW_WORD_OFFSET = BW_OFFSET - BW_BYTE_SEL;
	localparam int NUM_FIELDS = 6;

	// Field order is the order of the map
	localparam int FIELD_BASE [NUM_FIELDS] = '{PLATFORM_BASE, USERNAME_BASE, DATE_BASE,
		HOME_GIT_NAME_BASE, HOME_GIT_VERSION_BASE, DEVKIT_GIT_VERSION_BASE};
	localparam int FIELD_WORDS [NUM_FIELDS] = '{PLATFORM_WORDS, USERNAME_WORDS, DATE_WORDS,
		HOME_GIT_NAME_WORDS, HOME_GIT_VERSION_WORDS, DEVKIT_GIT_VERSION_WORDS};

	logic [BW_WORD_OFFSET-1:0] word_offset;
	logic [BW_BYTE_SEL-1:0] byte_sel;
	logic [BW_WORD_OFFSET-1:0] rel_offset [NUM_FIELDS];
	logic [NUM_FIELDS-1:0] field_hit;
	logic [BW_DATA-1:0] field_word [NUM_FIELDS];
	logic [BW_DATA-1:0] rd_word;
	logic mapped;
	logic access;
	logic bad_access;

	assign {word_offset, byte_sel} = bus.paddr[BW_OFFSET-1:0];

	// **************************************************
	// Per-field decode
	// **************************************************
	for (genvar f = 0; f < NUM_FIELDS; f++)
	begin : g_field
		assign rel_offset[f] = word_offset - BW_WORD_OFFSET'(FIELD_BASE[f]);
		assign field_hit[f] = (word_offset >= BW_WORD_OFFSET'(FIELD_BASE[f])) &&
			(word_offset < BW_WORD_OFFSET'(FIELD_BASE[f] + FIELD_WORDS[f]));
	end

	string_word_select #(.NUM_WORDS(PLATFORM_WORDS)) u_platform
	(
		.text(PLATFORM_NAME),
		.word_index(rel_offset[0][$clog2(PLATFORM_WORDS)-1:0]),
		.word(field_word[0])
	);

	string_word_select #(.NUM_WORDS(USERNAME_WORDS)) u_username
	(
		.text(USERNAME),
		.word_index(rel_offset[1][$clog2(USERNAME_WORDS)-1:0]),
		.word(field_word[1])
	);

	string_word_select #(.NUM_WORDS(DATE_WORDS)) u_date
	(
		.text(DESIGN_DATE),
		.word_index(rel_offset[2][$clog2(DATE_WORDS)-1:0]),
		.word(field_word[2])
	);

	string_word_select #(.NUM_WORDS(HOME_GIT_NAME_WORDS)) u_home_git_name
	(
		.text(HOME_GIT_NAME),
		.word_index(rel_offset[3][$clog2(HOME_GIT_NAME_WORDS)-1:0]),
		.word(field_word[3])
	);

	string_word_select #(.NUM_WORDS(HOME_GIT_VERSION_WORDS)) u_home_git_version
	(
		.text(HOME_GIT_VERSION),
		.word_index(rel_offset[4][$clog2(HOME_GIT_VERSION_WORDS)-1:0]),
		.word(field_word[4])
	);

	string_word_select #(.NUM_WORDS(DEVKIT_GIT_VERSION_WORDS)) u_devkit_git_version
	(
		.text(DEVKIT_GIT_VERSION),
		.word_index(rel_offset[5][$clog2(DEVKIT_GIT_VERSION_WORDS)-1:0]),
		.word(field_word[5])
	);

	// **************************************************
	// Read mux and response
	// **************************************************
	always_comb
	begin
		rd_word = '0;
		mapped = 1'b0;
		for (int f = 0; f < NUM_FIELDS; f++)
		begin
			if (field_hit[f])
			begin
				rd_word = field_word[f];
				mapped = 1'b1;
			end
		end
	end

	assign access = bus.psel & bus.penable;
	assign bad_access = (byte_sel != '0) | ~mapped;

	// No wait states; write data is dropped since every field is read-only
	assign bus.pready = access;
	assign bus.pslverr = access & bad_access;
	assign bus.prdata = (~bus.pwrite & ~bad_access) ? rd_word : '0;

endmodule

// ==== source/string_word_select.sv ====
module string_word_select import design_info_pkg::*;
#(
	parameter int NUM_WORDS = 4
)
(
	input logic [NUM_WORDS*BW_DATA-1:0] text,
	input logic [$clog2(NUM_WORDS)-1:0] word_index,
	output logic [BW_DATA-1:0] word
);

	localparam int CHARS_PER_WORD = BW_DATA / BITS_PER_CHAR;
	localparam int NUM_CHARS = NUM_WORDS * CHARS_PER_WORD;

	// Character 0 is the top byte of text and lands in word bits 7:0.
	// An index past the last word reads as zero
	always_comb
	begin
		word = '0;
		for (int w = 0; w < NUM_WORDS; w++)
		begin
			if (int'(word_index) == w)
			begin
				for (int c = 0; c < CHARS_PER_WORD; c++)
				begin
					word[c*BITS_PER_CHAR +: BITS_PER_CHAR] =
						text[(NUM_CHARS - 1 - w*CHARS_PER_WORD - c)*BITS_PER_CHAR +:
							BITS_PER_CHAR];
				end
			end
		end
	end

endmodule

// ==== source/apb_port_arbiter.sv ====
module apb_port_arbiter
(
	input logic clk,
	input logic rst_n,
	apb_if.completer port0,
	apb_if.completer port1,
	apb_if.requester target
);

	// **************************************************
	// Grant state
	// **************************************************
	logic busy;
	logic owner;
	logic last_served;

	logic pick;
	logic target_done;

	// On a tie the port not served last goes first
	always_comb
	begin
		if (port0.psel & port1.psel)
		begin
			pick = ~last_served;
		end
		else
		begin
			pick = port1.psel;
		end
	end

	assign target_done = target.psel & target.penable & target.pready;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			busy <= 1'b0;
			owner <= 1'b0;
			last_served <= 1'b1;
		end
		else if (busy)
		begin
			// Release on the edge that finishes the granted transfer
			if (target_done)
			begin
				busy <= 1'b0;
			end
		end
		else if (port0.psel | port1.psel)
		begin
			// A pending request in setup or stalled access is taken here
			busy <= 1'b1;
			owner <= pick;
			last_served <= pick;
		end
	end

	// **************************************************
	// Request path toward the register block
	// **************************************************
	assign target.psel = busy & (owner ? port1.psel : port0.psel);
	assign target.penable = busy & (owner ? port1.penable : port0.penable);
	assign target.pwrite = owner ? port1.pwrite : port0.pwrite;
	assign target.paddr = owner ? port1.paddr : port0.paddr;
	assign target.pwdata = owner ? port1.pwdata : port0.pwdata;

	// **************************************************
	// Responses, only the owner sees them
	// **************************************************
	assign port0.prdata = (busy & ~owner) ? target.prdata : '0;
	assign port0.pready = busy & ~owner & target.pready;
	assign port0.pslverr = busy & ~owner & target.pslverr;

	// The losing port waits with pready low
	assign port1.prdata = (busy & owner) ? target.prdata : '0;
	assign port1.pready = busy & owner & target.pready;
	assign port1.pslverr = busy & owner & target.pslverr;

endmodule

// ==== source/apb_if.sv ====
interface apb_if import design_info_pkg::*; ();

	logic psel;
	logic penable;
	logic pwrite;
	logic [BW_ADDR-1:0] paddr;
	logic [BW_DATA-1:0] pwdata;
	logic [BW_DATA-1:0] prdata;
	logic pready;
	logic pslverr;

	// Side that starts transfers
	modport requester
	(
		output psel, penable, pwrite, paddr, pwdata,
		input prdata, pready, pslverr
	);

	// Side that answers them
	modport completer
	(
		input psel, penable, pwrite, paddr, pwdata,
		output prdata, pready, pslverr
	);

endinterface

// ==== source/design_info_pkg.sv ====
package design_info_pkg;

	// **************************************************
	// Bus geometry
	// **************************************************
	localparam int BW_DATA = 32;
	localparam int BW_ADDR = 32;

	// 256-byte window, upper address bits are not decoded
	localparam int BW_OFFSET = 8;

	localparam int BITS_PER_CHAR = 8;

	// **************************************************
	// Word map, offsets in units of 32-bit words
	// **************************************************
	localparam int PLATFORM_BASE = 0;
	localparam int PLATFORM_WORDS = 4;

	localparam int USERNAME_BASE = 4;
	localparam int USERNAME_WORDS = 4;

	localparam int DATE_BASE = 8;
	localparam int DATE_WORDS = 5;

	localparam int HOME_GIT_NAME_BASE = 13;
	localparam int HOME_GIT_NAME_WORDS = 4;

	localparam int HOME_GIT_VERSION_BASE = 17;
	localparam int HOME_GIT_VERSION_WORDS = 2;

	localparam int DEVKIT_GIT_VERSION_BASE = 19;
	localparam int DEVKIT_GIT_VERSION_WORDS = 2;

	// Word offsets 21 and up answer with an error

	// **************************************************
	// Identification strings
	// **************************************************
	// Literal form, so the first character sits in the top byte
	localparam logic [PLATFORM_WORDS*BW_DATA-1:0] PLATFORM_NAME = "info_platform   ";

	localparam logic [USERNAME_WORDS*BW_DATA-1:0] USERNAME = "hw_team         ";

	localparam logic [DATE_WORDS*BW_DATA-1:0] DESIGN_DATE = "date_not_recorded   ";

	localparam logic [HOME_GIT_NAME_WORDS*BW_DATA-1:0] HOME_GIT_NAME = "home_repository ";

	localparam logic [HOME_GIT_VERSION_WORDS*BW_DATA-1:0] HOME_GIT_VERSION = "v1.4.2  ";

	localparam logic [DEVKIT_GIT_VERSION_WORDS*BW_DATA-1:0] DEVKIT_GIT_VERSION = "v2.0.7  ";

endpackage
